//--- src/rvc_pkg.sv
// rvc shared definitions
// opcodes, funct codes, register numbers, compressed formats and the
// stage structs of the compressed-instruction expander

package rvc_pkg;

  // ----------------------------------------
  // rv32i words and major opcodes
  // ----------------------------------------
  typedef logic [31:0] instr_t;

  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;

  localparam instr_t ebreak_word = 32'h0010_0073;

  // quadrant of a fetch word, taken from its low two bits
  typedef enum logic [1:0] {
    quad_c0   = 2'b00,
    quad_c1   = 2'b01,
    quad_c2   = 2'b10,
    quad_none = 2'b11
  } quadrant_e;

  // ----------------------------------------
  // quadrant-local funct3 codes
  // ----------------------------------------
  localparam logic [2:0] f3_c0_addi4spn = 3'b000;
  localparam logic [2:0] f3_c0_lw       = 3'b010;
  localparam logic [2:0] f3_c0_sw       = 3'b110;

  localparam logic [2:0] f3_c1_addi     = 3'b000;
  localparam logic [2:0] f3_c1_jal      = 3'b001;
  localparam logic [2:0] f3_c1_li       = 3'b010;
  localparam logic [2:0] f3_c1_lui      = 3'b011;
  localparam logic [2:0] f3_c1_misc_alu = 3'b100;
  localparam logic [2:0] f3_c1_j        = 3'b101;
  localparam logic [2:0] f3_c1_beqz     = 3'b110;
  localparam logic [2:0] f3_c1_bnez     = 3'b111;

  localparam logic [2:0] f3_c2_slli        = 3'b000;
  localparam logic [2:0] f3_c2_lwsp        = 3'b010;
  localparam logic [2:0] f3_c2_jalr_mv_add = 3'b100;
  localparam logic [2:0] f3_c2_swsp        = 3'b110;

  // register numbers
  localparam logic [4:0] reg_x0 = 5'd0;
  localparam logic [4:0] reg_ra = 5'd1;
  localparam logic [4:0] reg_sp = 5'd2;

  // prefix that turns a 3-bit prime register into x8..x15
  localparam logic [1:0] reg_prime_hi = 2'b01;

  // ----------------------------------------
  // compressed formats, msb first
  // ----------------------------------------
  typedef struct packed {
    logic [3:0] funct4;
    logic [4:0] rd_rs1;
    logic [4:0] rs2;
    logic [1:0] op;
  } cr_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic       imm_hi;
    logic [4:0] rd_rs1;
    logic [4:0] imm_lo;
    logic [1:0] op;
  } ci_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic [5:0] imm;
    logic [4:0] rs2;
    logic [1:0] op;
  } css_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic [7:0] imm;
    logic [2:0] rd_p;
    logic [1:0] op;
  } ciw_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic [2:0] imm_hi;
    logic [2:0] rs1_p;
    logic [1:0] imm_lo;
    logic [2:0] rd_p;
    logic [1:0] op;
  } cl_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic [2:0] imm_hi;
    logic [2:0] rs1_p;
    logic [1:0] imm_lo;
    logic [2:0] rs2_p;
    logic [1:0] op;
  } cs_t;

  // also covers the shift, andi and register alu layouts of quadrant 1
  typedef struct packed {
    logic [2:0] funct3;
    logic       imm_hi;
    logic [1:0] funct2;
    logic [2:0] rs1_p;
    logic [4:0] imm_lo;
    logic [1:0] op;
  } cb_t;

  typedef struct packed {
    logic [2:0]  funct3;
    logic [10:0] target;
    logic [1:0]  op;
  } cj_t;

  typedef union packed {
    cr_t  cr;
    ci_t  ci;
    css_t css;
    ciw_t ciw;
    cl_t  cl;
    cs_t  cs;
    cb_t  cb;
    cj_t  cj;
  } rvc_word_u;

  // ----------------------------------------
  // stage structs
  // ----------------------------------------
  typedef struct packed {
    logic      valid;
    quadrant_e quadrant;
    instr_t    word;
  } fetch_t;

  typedef struct packed {
    instr_t instr;
    logic   illegal;
  } expand_t;

  typedef struct packed {
    logic   valid;
    instr_t instr;
    logic   illegal;
    logic   is_compressed;
  } result_t;

endpackage

//--- src/rvc_fetch_reg.sv
// rvc fetch register
// captures the incoming fetch word with its strobe and classifies the
// quadrant once for the rest of the pipeline

`timescale 1ns/1ps

module rvc_fetch_reg (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            valid_i,
  input  rvc_pkg::instr_t instr_i,
  output rvc_pkg::fetch_t fetch_o
);

  import rvc_pkg::*;

  fetch_t fetch_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fetch_q <= '0;
    end else begin
      fetch_q.valid <= valid_i;
      // word and quadrant hold between strobes
      if (valid_i) begin
        fetch_q.quadrant <= quadrant_e'(instr_i[1:0]);
        fetch_q.word     <= instr_i;
      end
    end
  end

  assign fetch_o = fetch_q;

  // the strobe drives both later stages, an x here would spread through them
  a_valid_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !$isunknown(fetch_o.valid))
    else $error("fetch valid is unknown");

endmodule

//--- src/rvc_quadrant0.sv
// rvc quadrant 0 expander
// turns c.addi4spn, c.lw and c.sw into rv32i words

`timescale 1ns/1ps

module rvc_quadrant0 (
  input  rvc_pkg::rvc_word_u word_i,
  output rvc_pkg::expand_t   exp_o
);

  import rvc_pkg::*;

  always_comb begin
    exp_o = '0;

    unique case (word_i.ciw.funct3)
      f3_c0_addi4spn: begin
        // addi rd', sp, nzuimm
        exp_o.instr = {2'b00, word_i.ciw.imm[5:2], word_i.ciw.imm[7:6],
                       word_i.ciw.imm[0], word_i.ciw.imm[1], 2'b00,
                       reg_sp, 3'b000, reg_prime_hi, word_i.ciw.rd_p, opc_op_imm};
        // zero immediate is reserved
        exp_o.illegal = (word_i.ciw.imm == 8'h00);
      end

      f3_c0_lw: begin
        // lw rd', uimm(rs1')
        exp_o.instr = {5'b00000, word_i.cl.imm_lo[0], word_i.cl.imm_hi,
                       word_i.cl.imm_lo[1], 2'b00,
                       reg_prime_hi, word_i.cl.rs1_p, 3'b010,
                       reg_prime_hi, word_i.cl.rd_p, opc_load};
      end

      f3_c0_sw: begin
        // sw rs2', uimm(rs1')
        exp_o.instr = {5'b00000, word_i.cs.imm_lo[0], word_i.cs.imm_hi[2],
                       reg_prime_hi, word_i.cs.rs2_p,
                       reg_prime_hi, word_i.cs.rs1_p, 3'b010,
                       word_i.cs.imm_hi[1:0], word_i.cs.imm_lo[1], 2'b00,
                       opc_store};
      end

      // fp loads and stores, zcb and the reserved code
      default: begin
        exp_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

//--- src/rvc_quadrant1.sv
// rvc quadrant 1 expander
// immediates, lui and addi16sp, register alu, jumps and branches

`timescale 1ns/1ps

module rvc_quadrant1 (
  input  rvc_pkg::rvc_word_u word_i,
  output rvc_pkg::expand_t   exp_o
);

  import rvc_pkg::*;

  logic [10:0] cj_tgt;
  logic [19:0] jal_imm;
  logic [4:0]  rd_p;

  // j-type immediate field imm[20|10:1|11|19:12] from the cj target
  assign cj_tgt  = word_i.cj.target;
  assign jal_imm = {cj_tgt[10], cj_tgt[6], cj_tgt[8:7], cj_tgt[4], cj_tgt[5],
                    cj_tgt[0], cj_tgt[9], cj_tgt[3:1], {9{cj_tgt[10]}}};

  assign rd_p = {reg_prime_hi, word_i.cb.rs1_p};

  always_comb begin
    exp_o = '0;

    unique case (word_i.ci.funct3)
      f3_c1_addi: begin
        // c.nop is addi x0, x0, 0
        exp_o.instr = {{7{word_i.ci.imm_hi}}, word_i.ci.imm_lo, word_i.ci.rd_rs1,
                       3'b000, word_i.ci.rd_rs1, opc_op_imm};
      end

      f3_c1_jal: begin
        exp_o.instr = {jal_imm, reg_ra, opc_jal};
      end

      f3_c1_li: begin
        exp_o.instr = {{7{word_i.ci.imm_hi}}, word_i.ci.imm_lo, reg_x0,
                       3'b000, word_i.ci.rd_rs1, opc_op_imm};
      end

      f3_c1_lui: begin
        if (word_i.ci.rd_rs1 == reg_sp) begin
          // c.addi16sp, nzimm[9:4] scaled by 16
          exp_o.instr = {{3{word_i.ci.imm_hi}}, word_i.ci.imm_lo[2:1],
                         word_i.ci.imm_lo[3], word_i.ci.imm_lo[0],
                         word_i.ci.imm_lo[4], 4'b0000,
                         reg_sp, 3'b000, reg_sp, opc_op_imm};
        end else begin
          exp_o.instr = {{15{word_i.ci.imm_hi}}, word_i.ci.imm_lo,
                         word_i.ci.rd_rs1, opc_lui};
        end
        exp_o.illegal = ({word_i.ci.imm_hi, word_i.ci.imm_lo} == 6'd0);
      end

      f3_c1_misc_alu: begin
        unique case (word_i.cb.funct2)
          2'b00, 2'b01: begin
            // srli or srai, funct2[0] selects the arithmetic form
            exp_o.instr = {1'b0, word_i.cb.funct2[0], 4'b0000, word_i.cb.imm_hi,
                           word_i.cb.imm_lo, rd_p, 3'b101, rd_p, opc_op_imm};
          end

          2'b10: begin
            exp_o.instr = {{7{word_i.cb.imm_hi}}, word_i.cb.imm_lo,
                           rd_p, 3'b111, rd_p, opc_op_imm};
          end

          2'b11: begin
            // bit 12 set holds rv64 forms and zcb, none legal here
            if (word_i.cb.imm_hi) begin
              exp_o.illegal = 1'b1;
            end else begin
              unique case (word_i.cb.imm_lo[4:3])
                2'b00: exp_o.instr = {7'b0100000, reg_prime_hi, word_i.cb.imm_lo[2:0],
                                      rd_p, 3'b000, rd_p, opc_op};
                2'b01: exp_o.instr = {7'b0000000, reg_prime_hi, word_i.cb.imm_lo[2:0],
                                      rd_p, 3'b100, rd_p, opc_op};
                2'b10: exp_o.instr = {7'b0000000, reg_prime_hi, word_i.cb.imm_lo[2:0],
                                      rd_p, 3'b110, rd_p, opc_op};
                2'b11: exp_o.instr = {7'b0000000, reg_prime_hi, word_i.cb.imm_lo[2:0],
                                      rd_p, 3'b111, rd_p, opc_op};
              endcase
            end
          end
        endcase
      end

      f3_c1_j: begin
        exp_o.instr = {jal_imm, reg_x0, opc_jal};
      end

      f3_c1_beqz, f3_c1_bnez: begin
        // funct3 lsb picks beq or bne
        exp_o.instr = {{4{word_i.cb.imm_hi}}, word_i.cb.imm_lo[4:3], word_i.cb.imm_lo[0],
                       reg_x0, rd_p, 2'b00, word_i.cb.funct3[0],
                       word_i.cb.funct2, word_i.cb.imm_lo[2:1], word_i.cb.imm_hi,
                       opc_branch};
      end
    endcase
  end

  // a clean input word must never leave x on the expansion
  always_comb begin
    if (!$isunknown(word_i)) begin
      a_out_known: assert final (!$isunknown(exp_o))
        else $error("quadrant 1 expansion unknown for known word");
    end
  end

endmodule

//--- src/rvc_quadrant2.sv
// rvc quadrant 2 expander
// c.slli, stack-pointer load and store, and the jr/jalr/mv/add group

`timescale 1ns/1ps

module rvc_quadrant2 (
  input  rvc_pkg::rvc_word_u word_i,
  output rvc_pkg::expand_t   exp_o
);

  import rvc_pkg::*;

  always_comb begin
    exp_o = '0;

    unique case (word_i.ci.funct3)
      f3_c2_slli: begin
        exp_o.instr = {6'b000000, word_i.ci.imm_hi, word_i.ci.imm_lo,
                       word_i.ci.rd_rs1, 3'b001, word_i.ci.rd_rs1, opc_op_imm};
      end

      f3_c2_lwsp: begin
        // lw rd, uimm(sp), offset bits 7:6 sit in imm_lo[1:0]
        exp_o.instr = {4'b0000, word_i.ci.imm_lo[1:0], word_i.ci.imm_hi,
                       word_i.ci.imm_lo[4:2], 2'b00,
                       reg_sp, 3'b010, word_i.ci.rd_rs1, opc_load};
        exp_o.illegal = (word_i.ci.rd_rs1 == reg_x0);
      end

      f3_c2_jalr_mv_add: begin
        if (word_i.cr.rs2 == reg_x0) begin
          if (!word_i.cr.funct4[0]) begin
            // c.jr
            exp_o.instr   = {12'h000, word_i.cr.rd_rs1, 3'b000, reg_x0, opc_jalr};
            exp_o.illegal = (word_i.cr.rd_rs1 == reg_x0);
          end else if (word_i.cr.rd_rs1 == reg_x0) begin
            exp_o.instr = ebreak_word;
          end else begin
            // c.jalr links through ra
            exp_o.instr = {12'h000, word_i.cr.rd_rs1, 3'b000, reg_ra, opc_jalr};
          end
        end else if (!word_i.cr.funct4[0]) begin
          // c.mv
          exp_o.instr = {7'b0000000, word_i.cr.rs2, reg_x0, 3'b000,
                         word_i.cr.rd_rs1, opc_op};
        end else begin
          // c.add
          exp_o.instr = {7'b0000000, word_i.cr.rs2, word_i.cr.rd_rs1, 3'b000,
                         word_i.cr.rd_rs1, opc_op};
        end
      end

      f3_c2_swsp: begin
        // sw rs2, uimm(sp)
        exp_o.instr = {4'b0000, word_i.css.imm[1:0], word_i.css.imm[5],
                       word_i.css.rs2, reg_sp, 3'b010,
                       word_i.css.imm[4:2], 2'b00, opc_store};
      end

      // fp and rv64 stack-pointer forms
      default: begin
        exp_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

//--- src/rvc_result_reg.sv
// rvc result register
// picks the expansion for the stored quadrant, passes illegal and
// uncompressed words through unchanged and registers the result

`timescale 1ns/1ps

module rvc_result_reg (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  rvc_pkg::fetch_t  fetch_i,
  input  rvc_pkg::expand_t exp_q0_i,
  input  rvc_pkg::expand_t exp_q1_i,
  input  rvc_pkg::expand_t exp_q2_i,
  output rvc_pkg::result_t result_o
);

  import rvc_pkg::*;

  expand_t sel;
  result_t result_d;
  result_t result_q;

  // ----------------------------------------
  // select and passthrough
  // ----------------------------------------
  always_comb begin
    result_d               = '0;
    result_d.valid         = fetch_i.valid;
    result_d.is_compressed = 1'b1;

    unique case (fetch_i.quadrant)
      quad_c0: sel = exp_q0_i;
      quad_c1: sel = exp_q1_i;
      quad_c2: sel = exp_q2_i;
      default: begin
        sel                    = '{instr: fetch_i.word, illegal: 1'b0};
        result_d.is_compressed = 1'b0;
      end
    endcase

    result_d.illegal = sel.illegal;
    // an illegal word goes out as fetched
    result_d.instr   = sel.illegal ? fetch_i.word : sel.instr;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      result_q <= '0;
    end else begin
      result_q <= result_d;
    end
  end

  assign result_o = result_q;

  // only a compressed word can be flagged by the expanders
  a_illegal_compressed: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    result_o.illegal |-> result_o.is_compressed)
    else $error("illegal flag on an uncompressed word");

endmodule

//--- src/rvc_expander.sv
// rvc expander top level
// two-stage pipeline: fetch register, three quadrant expanders and the
// result register, with the result unpacked onto the ports

`timescale 1ns/1ps

module rvc_expander (
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            valid_i,
  input  rvc_pkg::instr_t instr_i,
  output logic            valid_o,
  output rvc_pkg::instr_t instr_o,
  output logic            illegal_o,
  output logic            is_compressed_o
);

  import rvc_pkg::*;

  fetch_t  fetch;
  expand_t exp_q0;
  expand_t exp_q1;
  expand_t exp_q2;
  result_t result;

  rvc_fetch_reg u_fetch_reg (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (valid_i),
    .instr_i  (instr_i),
    .fetch_o  (fetch)
  );

  // all three expanders see the low half of the stored word
  rvc_quadrant0 u_quadrant0 (.word_i(fetch.word[15:0]), .exp_o(exp_q0));
  rvc_quadrant1 u_quadrant1 (.word_i(fetch.word[15:0]), .exp_o(exp_q1));
  rvc_quadrant2 u_quadrant2 (.word_i(fetch.word[15:0]), .exp_o(exp_q2));

  rvc_result_reg u_result_reg (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .fetch_i  (fetch),
    .exp_q0_i (exp_q0),
    .exp_q1_i (exp_q1),
    .exp_q2_i (exp_q2),
    .result_o (result)
  );

  assign valid_o         = result.valid;
  assign instr_o         = result.instr;
  assign illegal_o       = result.illegal;
  assign is_compressed_o = result.is_compressed;

endmodule

//--- test/tb_rvc_checks.svh
// rvc expander testbench helpers
// rv32i reference encoders, xorshift source, compare tasks and the timed wait

`ifndef TB_RVC_CHECKS_SVH
`define TB_RVC_CHECKS_SVH

// rv32i major opcodes, straight from the base isa tables
localparam int rv_op_imm = 'h13;
localparam int rv_op     = 'h33;
localparam int rv_lui    = 'h37;
localparam int rv_load   = 'h03;
localparam int rv_store  = 'h23;
localparam int rv_branch = 'h63;
localparam int rv_jal    = 'h6f;
localparam int rv_jalr   = 'h67;
localparam int rv_system = 'h73;

int check_count  = 0;
int value_errors = 0;
int other_errors = 0;

logic [31:0] rng_state = 32'd13;

// ----------------------------------------
// reference encoders
// ----------------------------------------
function automatic rvc_pkg::instr_t enc_i(int imm, int rs1, int f3, int rd, int opc);
  return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
endfunction

function automatic rvc_pkg::instr_t enc_s(int imm, int rs2, int rs1, int f3, int opc);
  return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], opc[6:0]};
endfunction

function automatic rvc_pkg::instr_t enc_b(int imm, int rs2, int rs1, int f3);
  return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
          rv_branch[6:0]};
endfunction

// imm is the full value, its low 12 bits are dropped
function automatic rvc_pkg::instr_t enc_u(int imm, int rd, int opc);
  return {imm[31:12], rd[4:0], opc[6:0]};
endfunction

function automatic rvc_pkg::instr_t enc_j(int imm, int rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_jal[6:0]};
endfunction

function automatic rvc_pkg::instr_t enc_r(int f7, int rs2, int rs1, int f3, int rd, int opc);
  return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
endfunction

// xorshift32
function automatic logic [31:0] next_rand();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

// ----------------------------------------
// compare tasks
// ----------------------------------------
task automatic check_instr(input string name, input rvc_pkg::instr_t got,
                           input rvc_pkg::instr_t exp);
  check_count++;
  if (got !== exp) begin
    value_errors++;
    $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  check_count++;
  if (got !== exp) begin
    value_errors++;
    $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
  end
endtask

// counts rising edges until valid_o is seen, sampled just after each edge
task automatic wait_valid(input int max_cycles, output int cycles, output bit seen);
  cycles = 0;
  while (out_valid !== 1'b1 && cycles < max_cycles) begin
    @(posedge clk);
    #0.5;
    cycles++;
  end
  seen = (out_valid === 1'b1);
endtask

`endif

//--- test/tb_rvc_expander.sv
// rvc expander testbench
// directed tests per quadrant, passthrough of 32-bit words and a streaming run

`timescale 1ns/1ps

module tb_rvc_expander;

  logic            clk = 1'b0;
  logic            arst_n;
  logic            in_valid;
  rvc_pkg::instr_t in_instr;
  logic            out_valid;
  rvc_pkg::instr_t out_instr;
  logic            out_illegal;
  logic            out_compressed;

  `include "tb_rvc_checks.svh"

  always #2 clk = ~clk;

  rvc_expander u_dut (
    .clk_i           (clk),
    .arst_n_i        (arst_n),
    .valid_i         (in_valid),
    .instr_i         (in_instr),
    .valid_o         (out_valid),
    .instr_o         (out_instr),
    .illegal_o       (out_illegal),
    .is_compressed_o (out_compressed)
  );

  // ----------------------------------------
  // compressed word builders
  // ----------------------------------------
  function automatic logic [15:0] c_addi4spn(int rdp, int u);
    return {3'b000, u[5:4], u[9:6], u[2], u[3], rdp[2:0], 2'b00};
  endfunction

  // c.lw and c.sw share one layout where rdp doubles as rs2'
  function automatic logic [15:0] c_lsw(int f3, int rs1p, int rdp, int u);
    return {f3[2:0], u[5:3], rs1p[2:0], u[2], u[6], rdp[2:0], 2'b00};
  endfunction

  function automatic logic [15:0] c_ci(int f3, int imm, int rd, int op);
    return {f3[2:0], imm[5], rd[4:0], imm[4:0], op[1:0]};
  endfunction

  function automatic logic [15:0] c_addi16sp(int imm);
    return {3'b011, imm[9], 5'd2, imm[4], imm[6], imm[8:7], imm[5], 2'b01};
  endfunction

  function automatic logic [15:0] c_cb_imm(int f2, int rdp, int imm);
    return {3'b100, imm[5], f2[1:0], rdp[2:0], imm[4:0], 2'b01};
  endfunction

  function automatic logic [15:0] c_alu(int op, int rdp, int rs2p);
    return {3'b100, 1'b0, 2'b11, rdp[2:0], op[1:0], rs2p[2:0], 2'b01};
  endfunction

  function automatic logic [15:0] c_cj(int f3, int off);
    return {f3[2:0], off[11], off[4], off[9:8], off[10], off[6], off[7], off[3:1], off[5],
            2'b01};
  endfunction

  function automatic logic [15:0] c_br(int f3, int rs1p, int off);
    return {f3[2:0], off[8], off[4:3], rs1p[2:0], off[7:6], off[2:1], off[5], 2'b01};
  endfunction

  function automatic logic [15:0] c_lwsp(int rd, int u);
    return {3'b010, u[5], rd[4:0], u[4:2], u[7:6], 2'b10};
  endfunction

  function automatic logic [15:0] c_swsp(int rs2, int u);
    return {3'b110, u[5:2], u[7:6], rs2[4:0], 2'b10};
  endfunction

  function automatic logic [15:0] c_cr(int f4, int rd, int rs2);
    return {f4[3:0], rd[4:0], rs2[4:0], 2'b10};
  endfunction

  // ----------------------------------------
  // single transaction
  // ----------------------------------------
  task automatic run_word(input string label, input rvc_pkg::instr_t word,
                          input rvc_pkg::instr_t exp_instr, input logic exp_illegal,
                          input logic exp_comp);
    int cycles;
    bit seen;
    @(posedge clk);
    #0.5;
    in_valid = 1'b1;
    in_instr = word;
    @(posedge clk);
    #0.5;
    in_valid = 1'b0;
    wait_valid(8, cycles, seen);
    if (!seen) begin
      other_errors++;
      $display("%s: valid_o never came high", label);
    end else begin
      // the sampling edge is the first of the two pipeline edges
      if (cycles + 1 != 2) begin
        other_errors++;
        $display("%s: valid_o came %0d edges after the strobe instead of 2",
                 label, cycles + 1);
      end
      check_instr({label, " instr_o"}, out_instr, exp_instr);
      check_flag({label, " illegal_o"}, out_illegal, exp_illegal);
      check_flag({label, " is_compressed_o"}, out_compressed, exp_comp);
    end
  endtask

  // the upper half gets random bits so that an illegal word must come back whole
  task automatic run_c(input string label, input logic [15:0] cw,
                       input rvc_pkg::instr_t exp_instr, input logic exp_illegal);
    logic [31:0]     r;
    rvc_pkg::instr_t word;
    r    = next_rand();
    word = {r[31:16], cw};
    run_word(label, word, exp_illegal ? word : exp_instr, exp_illegal, cw[1:0] != 2'b11);
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic test_reset_timing();
    repeat (4) begin
      @(posedge clk);
      #0.5;
      check_flag("idle valid_o", out_valid, 1'b0);
    end
    run_c("first c.addi", c_ci(0, 1, 1, 1), enc_i(1, 1, 0, 1, rv_op_imm), 1'b0);
  endtask

  task automatic test_quadrant0();
    run_c("c.addi4spn", c_addi4spn(0, 4), enc_i(4, 2, 0, 8, rv_op_imm), 1'b0);
    run_c("c.addi4spn max", c_addi4spn(7, 1020), enc_i(1020, 2, 0, 15, rv_op_imm), 1'b0);
    run_c("c.lw", c_lsw(2, 1, 2, 124), enc_i(124, 9, 2, 10, rv_load), 1'b0);
    run_c("c.lw small", c_lsw(2, 6, 3, 4), enc_i(4, 14, 2, 11, rv_load), 1'b0);
    run_c("c.sw", c_lsw(6, 4, 5, 64), enc_s(64, 13, 12, 2, rv_store), 1'b0);
    run_c("c.addi4spn zero", c_addi4spn(5, 0), '0, 1'b1);
    run_c("c.fld", 16'h2c48, '0, 1'b1);
  endtask

  task automatic test_quadrant1();
    run_c("c.addi", c_ci(0, -3, 10, 1), enc_i(-3, 10, 0, 10, rv_op_imm), 1'b0);
    run_c("c.nop", c_ci(0, 0, 0, 1), enc_i(0, 0, 0, 0, rv_op_imm), 1'b0);
    run_c("c.li", c_ci(2, 17, 7, 1), enc_i(17, 0, 0, 7, rv_op_imm), 1'b0);
    run_c("c.lui neg", c_ci(3, -1, 3, 1), enc_u(-4096, 3, rv_lui), 1'b0);
    run_c("c.lui", c_ci(3, 5, 9, 1), enc_u(5 * 4096, 9, rv_lui), 1'b0);
    run_c("c.addi16sp neg", c_addi16sp(-64), enc_i(-64, 2, 0, 2, rv_op_imm), 1'b0);
    run_c("c.addi16sp", c_addi16sp(496), enc_i(496, 2, 0, 2, rv_op_imm), 1'b0);
    run_c("c.srli", c_cb_imm(0, 1, 7), enc_i(7, 9, 5, 9, rv_op_imm), 1'b0);
    run_c("c.srai", c_cb_imm(1, 2, 31), enc_i('h41f, 10, 5, 10, rv_op_imm), 1'b0);
    run_c("c.andi", c_cb_imm(2, 3, -8), enc_i(-8, 11, 7, 11, rv_op_imm), 1'b0);
    run_c("c.sub", c_alu(0, 4, 5), enc_r('h20, 13, 12, 0, 12, rv_op), 1'b0);
    run_c("c.xor", c_alu(1, 0, 7), enc_r(0, 15, 8, 4, 8, rv_op), 1'b0);
    run_c("c.or", c_alu(2, 6, 1), enc_r(0, 9, 14, 6, 14, rv_op), 1'b0);
    run_c("c.and", c_alu(3, 2, 2), enc_r(0, 10, 10, 7, 10, rv_op), 1'b0);
    run_c("c.jal", c_cj(1, -2048), enc_j(-2048, 1), 1'b0);
    run_c("c.j", c_cj(5, 1022), enc_j(1022, 0), 1'b0);
    run_c("c.beqz", c_br(6, 0, -256), enc_b(-256, 0, 8, 0), 1'b0);
    run_c("c.bnez", c_br(7, 7, 254), enc_b(254, 0, 15, 1), 1'b0);
    run_c("c.lui zero", c_ci(3, 0, 5, 1), '0, 1'b1);
    run_c("c.subw", 16'h9c89, '0, 1'b1);
  endtask

  task automatic test_quadrant2();
    run_c("c.slli", c_ci(0, 13, 20, 2), enc_i(13, 20, 1, 20, rv_op_imm), 1'b0);
    run_c("c.lwsp", c_lwsp(5, 252), enc_i(252, 2, 2, 5, rv_load), 1'b0);
    run_c("c.swsp", c_swsp(31, 128), enc_s(128, 31, 2, 2, rv_store), 1'b0);
    run_c("c.mv", c_cr(8, 6, 7), enc_r(0, 7, 0, 0, 6, rv_op), 1'b0);
    run_c("c.add", c_cr(9, 6, 7), enc_r(0, 7, 6, 0, 6, rv_op), 1'b0);
    run_c("c.jr", c_cr(8, 1, 0), enc_i(0, 1, 0, 0, rv_jalr), 1'b0);
    run_c("c.jalr", c_cr(9, 12, 0), enc_i(0, 12, 0, 1, rv_jalr), 1'b0);
    run_c("c.ebreak", c_cr(9, 0, 0), enc_i(1, 0, 0, 0, rv_system), 1'b0);
    run_c("c.lwsp x0", c_lwsp(0, 8), '0, 1'b1);
    run_c("c.jr x0", c_cr(8, 0, 0), '0, 1'b1);
  endtask

  task automatic test_uncompressed();
    logic [31:0] w;
    repeat (8) begin
      w = next_rand() | 32'h3;
      run_word("uncompressed", w, w, 1'b0, 1'b0);
    end
  endtask

  // maps a random word onto one of eight legal compressed forms
  task automatic legal_form(input logic [31:0] r, output logic [15:0] cw,
                            output rvc_pkg::instr_t exp);
    int rdp;
    int rs2p;
    int rd;
    int s6;
    int u;
    int off;
    int f3;
    rdp  = int'((r >> 3) & 7);
    rs2p = int'((r >> 6) & 7);
    rd   = int'((r >> 9) & 31);
    s6   = int'((r >> 14) & 63) - (r[19] ? 64 : 0);
    case (r[2:0])
      3'd0: begin
        cw  = c_ci(0, s6, rd, 1);
        exp = enc_i(s6, rd, 0, rd, rv_op_imm);
      end
      3'd1: begin
        u   = int'((r >> 16) & 31) * 4;
        cw  = c_lsw(2, rdp, rs2p, u);
        exp = enc_i(u, 8 + rdp, 2, 8 + rs2p, rv_load);
      end
      3'd2: begin
        u   = int'((r >> 16) & 31) * 4;
        cw  = c_lsw(6, rdp, rs2p, u);
        exp = enc_s(u, 8 + rs2p, 8 + rdp, 2, rv_store);
      end
      3'd3: begin
        cw  = c_cb_imm(2, rdp, s6);
        exp = enc_i(s6, 8 + rdp, 7, 8 + rdp, rv_op_imm);
      end
      3'd4: begin
        case (r[10:9])
          2'd0: f3 = 0;
          2'd1: f3 = 4;
          2'd2: f3 = 6;
          default: f3 = 7;
        endcase
        cw  = c_alu(int'((r >> 9) & 3), rdp, rs2p);
        exp = enc_r(r[10:9] == 2'd0 ? 'h20 : 0, 8 + rs2p, 8 + rdp, f3, 8 + rdp, rv_op);
      end
      3'd5: begin
        off = int'((r >> 10) & 'h7ff) * 2 - (r[20] ? 4096 : 0);
        cw  = c_cj(5, off);
        exp = enc_j(off, 0);
      end
      3'd6: begin
        off = int'((r >> 9) & 'hff) * 2 - (r[16] ? 512 : 0);
        cw  = c_br(7, rdp, off);
        exp = enc_b(off, 0, 8 + rdp, 1);
      end
      default: begin
        u   = int'((r >> 15) & 63) * 4;
        cw  = c_swsp(rd, u);
        exp = enc_s(u, rd, 2, 2, rv_store);
      end
    endcase
  endtask

  task automatic test_streaming();
    logic [15:0]     cw;
    logic [31:0]     upper;
    rvc_pkg::instr_t e;
    rvc_pkg::instr_t words[16];
    rvc_pkg::instr_t exp_q[$];
    int              received;
    int              first;
    int              j;
    for (int i = 0; i < 16; i++) begin
      legal_form(next_rand(), cw, e);
      upper    = next_rand();
      words[i] = {upper[15:0], cw};
      exp_q.push_back(e);
    end
    received = 0;
    first    = -1;
    j        = 0;
    // results are sampled just after the edge and before the next word goes in
    while (received < 16 && j < 26) begin
      @(posedge clk);
      #0.5;
      if (out_valid === 1'b1) begin
        if (first < 0) begin
          first = j;
        end
        if (j - first != received) begin
          other_errors++;
          $display("stream result %0d arrived after a gap", received);
        end
        check_instr("stream instr_o", out_instr, exp_q.pop_front());
        check_flag("stream illegal_o", out_illegal, 1'b0);
        check_flag("stream is_compressed_o", out_compressed, 1'b1);
        received++;
      end
      in_valid = (j < 16);
      if (j < 16) begin
        in_instr = words[j];
      end
      j++;
    end
    in_valid = 1'b0;
    if (received < 16) begin
      other_errors++;
      $display("stream timed out with %0d of 16 results", received);
    end else if (first != 2) begin
      other_errors++;
      $display("first stream result came in cycle %0d instead of 2", first);
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    arst_n   = 1'b0;
    in_valid = 1'b0;
    in_instr = '0;
    repeat (4) @(posedge clk);
    #0.5;
    arst_n = 1'b1;

    test_reset_timing();
    test_quadrant0();
    test_quadrant1();
    test_quadrant2();
    test_uncompressed();
    test_streaming();

    $display("%0d checks, %0d value errors, %0d other errors",
             check_count, value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- rvc_expander.f
+incdir+test
src/rvc_pkg.sv
src/rvc_fetch_reg.sv
src/rvc_quadrant0.sv
src/rvc_quadrant1.sv
src/rvc_quadrant2.sv
src/rvc_result_reg.sv
src/rvc_expander.sv
test/tb_rvc_expander.sv

//--- Makefile
# Verilator build, run and lint for the RVC expander

VERILATOR   ?= verilator
TOP         ?= tb_rvc_expander
DUT_TOP     ?= rvc_expander
FILELIST    ?= rvc_expander.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS  ?= --lint-only -Wall --timing
PASS_TEXT   ?= TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only when the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
